//--- src/sram_bist_pkg.sv
// shared widths, test numbering, pattern words and bus structs for the SRAM BIST
package sram_bist_pkg;

   // -------------------------------------------------------------------------
   // widths and counts
   // -------------------------------------------------------------------------
   localparam int sram_addr_width = 8;   // shrunk for short simulations
   localparam int sram_data_width = 36;
   localparam int num_tests       = 5;
   localparam int num_chips       = 2;
   localparam int rand_test_idx   = 4;   // tests 0..3 are fixed patterns

   typedef logic [sram_addr_width-1:0] sram_addr_t;
   typedef logic [sram_data_width-1:0] sram_data_t;
   typedef logic [2:0]                 test_idx_t;
   typedef logic [num_tests-1:0]       test_mask_t;
   typedef logic [num_chips-1:0]       chip_mask_t;

   // -------------------------------------------------------------------------
   // pattern words and LFSR
   // -------------------------------------------------------------------------
   localparam sram_data_t pattern_0 = 36'h0_0000_0000;   // all zeros
   localparam sram_data_t pattern_1 = 36'hF_FFFF_FFFF;   // all ones
   localparam sram_data_t pattern_2 = 36'h5_5555_5555;
   localparam sram_data_t pattern_3 = 36'hA_AAAA_AAAA;

   // lower feedback tap, the upper tap is the msb
   localparam int lfsr_tap = 24;

   // -------------------------------------------------------------------------
   // structs
   // -------------------------------------------------------------------------

   // request to one chip, held stable until ack
   typedef struct packed {
      logic       req;
      logic       rd;
      sram_addr_t addr;
      sram_data_t wr_data;
   } mem_req_t;

   // response from one chip, ack is a single cycle pulse
   typedef struct packed {
      logic       ack;
      sram_data_t rd_data;   // valid with ack on reads
   } mem_rsp_t;

   // one mismatch record
   typedef struct packed {
      logic       vld;
      logic       chip;      // filled in by the sequencer
      sram_addr_t addr;
      sram_data_t exp_data;
      sram_data_t rd_data;
   } err_log_t;

endpackage

//--- src/fixed_pattern_tester.sv
// fixed pattern test, writes one word to every address then reads back and compares
module fixed_pattern_tester (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      start,
   input  sram_bist_pkg::sram_data_t pattern,
   input  sram_bist_pkg::mem_rsp_t   rsp,
   output sram_bist_pkg::mem_req_t   req,
   output logic                      done,
   output logic                      fail,
   output sram_bist_pkg::err_log_t   err_log
);
   import sram_bist_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_write,
      st_read
   } state_t;

   state_t     state;
   logic       req_q;
   sram_addr_t addr_q;      // also the pass counter
   sram_data_t pattern_q;
   logic       last_addr;
   logic       mismatch;
   logic       log_vld_q;
   sram_addr_t log_addr_q;
   sram_data_t log_rd_q;

   assign last_addr = (addr_q == {sram_addr_width{1'b1}});
   assign mismatch  = (state == st_read) && rsp.ack && (rsp.rd_data != pattern_q);

   // ------------------------------------------------------------------------
   // pass control
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= st_idle;
         req_q     <= 1'b0;
         done      <= 1'b0;
         fail      <= 1'b0;
         log_vld_q <= 1'b0;
      end else begin
         done      <= 1'b0;
         log_vld_q <= mismatch;   // record goes out the cycle after ack
         if (mismatch)
            fail <= 1'b1;
         case (state)
            st_idle: if (start) begin
               state <= st_write;
               req_q <= 1'b1;
               fail  <= 1'b0;
            end
            st_write: if (rsp.ack && last_addr) begin
               state <= st_read;   // req stays up, rd flips
            end
            st_read: if (rsp.ack && last_addr) begin
               state <= st_idle;
               req_q <= 1'b0;
               done  <= 1'b1;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // address, pattern and log payload
   always_ff @(posedge clk) begin
      if (state == st_idle && start) begin
         pattern_q <= pattern;
         addr_q    <= '0;
      end else if (state != st_idle && rsp.ack) begin
         addr_q <= addr_q + 1'b1;   // wraps to zero for the read pass
      end
      if (mismatch) begin
         log_addr_q <= addr_q;
         log_rd_q   <= rsp.rd_data;
      end
   end

   assign req = '{req: req_q, rd: (state == st_read), addr: addr_q, wr_data: pattern_q};

   assign err_log = '{vld: log_vld_q, chip: 1'b0, addr: log_addr_q,
                      exp_data: pattern_q, rd_data: log_rd_q};

endmodule

//--- src/random_pattern_tester.sv
// pseudo-random test, writes an LFSR sequence from the seed then replays it on read-back
module random_pattern_tester (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      start,
   input  sram_bist_pkg::sram_data_t seed,
   input  sram_bist_pkg::mem_rsp_t   rsp,
   output sram_bist_pkg::mem_req_t   req,
   output logic                      done,
   output logic                      fail,
   output sram_bist_pkg::err_log_t   err_log
);
   import sram_bist_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_write,
      st_read
   } state_t;

   state_t     state;
   logic       req_q;
   sram_addr_t addr_q;
   sram_data_t seed_fix;    // zero seed would lock the LFSR
   sram_data_t seed_q;      // kept to restart the read pass
   sram_data_t lfsr_q;      // word for the current address
   logic       last_addr;
   logic       mismatch;
   logic       log_vld_q;
   sram_addr_t log_addr_q;
   sram_data_t log_exp_q;
   sram_data_t log_rd_q;

   // shift left, new lsb from msb xor tap
   function automatic sram_data_t lfsr_step(input sram_data_t v);
      return {v[sram_data_width-2:0], v[sram_data_width-1] ^ v[lfsr_tap]};
   endfunction

   assign seed_fix  = (seed == '0) ? {sram_data_width{1'b1}} : seed;
   assign last_addr = (addr_q == {sram_addr_width{1'b1}});
   assign mismatch  = (state == st_read) && rsp.ack && (rsp.rd_data != lfsr_q);

   // ------------------------------------------------------------------------
   // pass control
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= st_idle;
         req_q     <= 1'b0;
         done      <= 1'b0;
         fail      <= 1'b0;
         log_vld_q <= 1'b0;
      end else begin
         done      <= 1'b0;
         log_vld_q <= mismatch;
         if (mismatch)
            fail <= 1'b1;
         case (state)
            st_idle: if (start) begin
               state <= st_write;
               req_q <= 1'b1;
               fail  <= 1'b0;
            end
            st_write: if (rsp.ack && last_addr)
               state <= st_read;
            st_read: if (rsp.ack && last_addr) begin
               state <= st_idle;
               req_q <= 1'b0;
               done  <= 1'b1;   // one cycle after the last read ack
            end
            default: state <= st_idle;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // address counter, LFSR and log payload
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (state == st_idle && start) begin
         seed_q <= seed_fix;
         lfsr_q <= seed_fix;
         addr_q <= '0;
      end else if (state != st_idle && rsp.ack) begin
         addr_q <= addr_q + 1'b1;
         if (state == st_write && last_addr)
            lfsr_q <= seed_q;               // replay from the seed
         else
            lfsr_q <= lfsr_step(lfsr_q);
      end
      if (mismatch) begin
         log_addr_q <= addr_q;
         log_exp_q  <= lfsr_q;
         log_rd_q   <= rsp.rd_data;
      end
   end

   assign req = '{req: req_q, rd: (state == st_read), addr: addr_q, wr_data: lfsr_q};

   assign err_log = '{vld: log_vld_q, chip: 1'b0, addr: log_addr_q,
                      exp_data: log_exp_q, rd_data: log_rd_q};

endmodule

//--- src/bist_sequencer.sv
// steps through chips and tests, starts the testers and routes the active one to a chip
module bist_sequencer (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      test_start,
   input  sram_bist_pkg::test_mask_t test_en,
   input  sram_bist_pkg::chip_mask_t sram_en,
   input  sram_bist_pkg::sram_data_t rand_seed,
   output logic                      running,
   output logic                      done,
   output logic                      fail,
   output logic                      fixed_start,
   output logic                      rand_start,
   output sram_bist_pkg::sram_data_t pattern,
   output sram_bist_pkg::sram_data_t seed,
   input  sram_bist_pkg::mem_req_t   fixed_req,
   input  sram_bist_pkg::mem_req_t   rand_req,
   input  logic                      fixed_done,
   input  logic                      fixed_fail,
   input  logic                      rand_done,
   input  logic                      rand_fail,
   input  sram_bist_pkg::err_log_t   fixed_log,
   input  sram_bist_pkg::err_log_t   rand_log,
   output sram_bist_pkg::mem_rsp_t   tester_rsp,
   output sram_bist_pkg::mem_req_t   sram_req_0,
   output sram_bist_pkg::mem_req_t   sram_req_1,
   input  sram_bist_pkg::mem_rsp_t   sram_rsp_0,
   input  sram_bist_pkg::mem_rsp_t   sram_rsp_1,
   output sram_bist_pkg::err_log_t   err_log
);
   import sram_bist_pkg::*;

   typedef enum logic [1:0] {c_idle, c_check, c_wait} chip_state_t;
   typedef enum logic [1:0] {t_idle, t_check, t_wait} test_state_t;

   chip_state_t chip_state;
   test_state_t test_state;
   logic        chip_idx;
   test_idx_t   test_idx;
   test_mask_t  test_en_q;
   chip_mask_t  sram_en_q;
   sram_data_t  seed_q;
   logic        chip_go;       // kick off the test loop on this chip
   logic        tests_done;    // test loop finished for this chip
   logic        last_chip;
   logic        last_test;
   logic        is_rand;
   logic        in_flight;
   logic        active_done;
   logic        active_fail;
   mem_req_t    active_req;
   mem_req_t    idle_req;

   assign running   = (chip_state != c_idle);
   assign last_chip = (chip_idx == 1'(num_chips - 1));
   assign last_test = (test_idx == test_idx_t'(num_tests - 1));
   assign is_rand   = (test_idx == test_idx_t'(rand_test_idx));
   assign in_flight = (test_state == t_wait);
   assign chip_go   = (chip_state == c_check) && sram_en_q[chip_idx];

   assign active_done = is_rand ? rand_done : fixed_done;
   assign active_fail = is_rand ? rand_fail : fixed_fail;
   assign active_req  = is_rand ? rand_req : fixed_req;

   // ------------------------------------------------------------------------
   // chip loop
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         chip_state <= c_idle;
         chip_idx   <= 1'b0;
         done       <= 1'b0;
         fail       <= 1'b0;
      end else begin
         if (in_flight && active_done && active_fail)
            fail <= 1'b1;   // sticky over the whole run
         case (chip_state)
            c_idle: if (test_start) begin
               chip_state <= c_check;
               chip_idx   <= 1'b0;
               done       <= 1'b0;
               fail       <= 1'b0;
            end
            c_check, c_wait: if (chip_state == c_wait ? tests_done : !chip_go) begin
               if (last_chip) begin
                  chip_state <= c_idle;
                  done       <= 1'b1;
               end else begin
                  chip_state <= c_check;
                  chip_idx   <= chip_idx + 1'b1;
               end
            end else if (chip_go) begin
               chip_state <= c_wait;
            end
            default: chip_state <= c_idle;
         endcase
      end
   end

   // settings are sampled once per run
   always_ff @(posedge clk) begin
      if (chip_state == c_idle && test_start) begin
         test_en_q <= test_en;
         sram_en_q <= sram_en;
         seed_q    <= rand_seed;
      end
   end

   // ------------------------------------------------------------------------
   // test loop within one chip
   // ------------------------------------------------------------------------
   assign fixed_start = (test_state == t_check) && test_en_q[test_idx] && !is_rand;
   assign rand_start  = (test_state == t_check) && test_en_q[test_idx] && is_rand;
   assign tests_done  = last_test && ((test_state == t_check && !test_en_q[test_idx]) ||
                                      (in_flight && active_done));

   always_ff @(posedge clk) begin
      if (reset) begin
         test_state <= t_idle;
         test_idx   <= '0;
      end else begin
         case (test_state)
            t_idle: if (chip_go) begin
               test_state <= t_check;
               test_idx   <= '0;
            end
            t_check: if (test_en_q[test_idx])
               test_state <= t_wait;
            else if (last_test)
               test_state <= t_idle;
            else
               test_idx <= test_idx + 1'b1;   // skip, one cycle per test
            t_wait: if (active_done) begin
               test_state <= last_test ? t_idle : t_check;
               if (!last_test)
                  test_idx <= test_idx + 1'b1;
            end
            default: test_state <= t_idle;
         endcase
      end
   end

   always_comb begin
      case (test_idx)
         3'd0:    pattern = pattern_0;
         3'd1:    pattern = pattern_1;
         3'd2:    pattern = pattern_2;
         3'd3:    pattern = pattern_3;
         default: pattern = pattern_0;
      endcase
   end

   assign seed = seed_q;

   // ------------------------------------------------------------------------
   // chip routing and log forwarding
   // ------------------------------------------------------------------------
   assign idle_req = '{req: 1'b0, rd: 1'b1, addr: '0, wr_data: '0};

   always_comb begin
      sram_req_0 = idle_req;
      sram_req_1 = idle_req;
      tester_rsp = '0;
      if (in_flight) begin
         if (chip_idx) begin
            sram_req_1 = active_req;
            tester_rsp = sram_rsp_1;
         end else begin
            sram_req_0 = active_req;
            tester_rsp = sram_rsp_0;
         end
      end
      err_log      = is_rand ? rand_log : fixed_log;
      err_log.chip = chip_idx;
      err_log.vld  = err_log.vld && in_flight;
   end

endmodule

//--- src/sram_bist_top.sv
// SRAM BIST top level, ties the fixed and random testers to the chip sequencer
module sram_bist_top (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      test_start,
   input  sram_bist_pkg::test_mask_t test_en,
   input  sram_bist_pkg::chip_mask_t sram_en,
   input  sram_bist_pkg::sram_data_t rand_seed,
   output logic                      running,
   output logic                      done,
   output logic                      fail,
   output sram_bist_pkg::err_log_t   err_log,
   output sram_bist_pkg::mem_req_t   sram_req_0,
   output sram_bist_pkg::mem_req_t   sram_req_1,
   input  sram_bist_pkg::mem_rsp_t   sram_rsp_0,
   input  sram_bist_pkg::mem_rsp_t   sram_rsp_1
);
   import sram_bist_pkg::*;

   logic       fixed_start;
   logic       rand_start;
   sram_data_t pattern;
   sram_data_t seed;
   mem_rsp_t   tester_rsp;   // shared, only the active tester has req up
   mem_req_t   fixed_req;
   mem_req_t   rand_req;
   logic       fixed_done;
   logic       fixed_fail;
   logic       rand_done;
   logic       rand_fail;
   err_log_t   fixed_log;
   err_log_t   rand_log;

   // ------------------------------------------------------------------------
   // testers
   // ------------------------------------------------------------------------
   fixed_pattern_tester u_fixed (
      .clk     (clk),
      .reset   (reset),
      .start   (fixed_start),
      .pattern (pattern),
      .rsp     (tester_rsp),
      .req     (fixed_req),
      .done    (fixed_done),
      .fail    (fixed_fail),
      .err_log (fixed_log)
   );

   random_pattern_tester u_rand (
      .clk     (clk),
      .reset   (reset),
      .start   (rand_start),
      .seed    (seed),
      .rsp     (tester_rsp),
      .req     (rand_req),
      .done    (rand_done),
      .fail    (rand_fail),
      .err_log (rand_log)
   );

   // chip and test loops
   bist_sequencer u_seq (
      .clk         (clk),
      .reset       (reset),
      .test_start  (test_start),
      .test_en     (test_en),
      .sram_en     (sram_en),
      .rand_seed   (rand_seed),
      .running     (running),
      .done        (done),
      .fail        (fail),
      .fixed_start (fixed_start),
      .rand_start  (rand_start),
      .pattern     (pattern),
      .seed        (seed),
      .fixed_req   (fixed_req),
      .rand_req    (rand_req),
      .fixed_done  (fixed_done),
      .fixed_fail  (fixed_fail),
      .rand_done   (rand_done),
      .rand_fail   (rand_fail),
      .fixed_log   (fixed_log),
      .rand_log    (rand_log),
      .tester_rsp  (tester_rsp),
      .sram_req_0  (sram_req_0),
      .sram_req_1  (sram_req_1),
      .sram_rsp_0  (sram_rsp_0),
      .sram_rsp_1  (sram_rsp_1),
      .err_log     (err_log)
   );

endmodule

//--- test/sram_model.sv
// behavioral SRAM for the BIST testbench, acks after a random delay, one stuck-at-one bit
module sram_model (
   input  logic                      clk,
   input  logic                      reset,
   input  sram_bist_pkg::mem_req_t   req,
   output sram_bist_pkg::mem_rsp_t   rsp,
   input  logic                      fault_en,
   input  sram_bist_pkg::sram_addr_t fault_addr,
   input  logic [5:0]                fault_bit
);
   timeunit 1ns;
   timeprecision 1ps;
   import sram_bist_pkg::*;

   sram_data_t  mem [2**sram_addr_width];
   logic        busy;        // access accepted, ack still pending
   int unsigned wait_left;
   int unsigned draw;
   sram_data_t  word;

   always @(posedge clk) begin
      draw = $urandom_range(3, 0);   // extra wait cycles, ack after 1 to 4
      rsp.ack <= 1'b0;
      if (reset) begin
         busy <= 1'b0;
      end else if (req.req && !rsp.ack) begin
         if (busy ? (wait_left == 0) : (draw == 0)) begin
            busy    <= 1'b0;
            rsp.ack <= 1'b1;
            if (req.rd) begin
               word = mem[req.addr];
               if (fault_en && req.addr == fault_addr)
                  word[fault_bit] = 1'b1;   // stuck at one on read
               rsp.rd_data <= word;
            end else begin
               mem[req.addr] <= req.wr_data;
            end
         end else if (busy) begin
            wait_left <= wait_left - 1;
         end else begin
            busy      <= 1'b1;
            wait_left <= draw - 1;
         end
      end
   end

endmodule

//--- test/sram_bist_chk.sv
// protocol assertions for the BIST sequencer, attached to every bist_sequencer by bind
module sram_bist_chk (
   input logic                    clk,
   input logic                    reset,
   input logic                    running,
   input logic                    done,
   input sram_bist_pkg::err_log_t err_log,
   input sram_bist_pkg::mem_req_t sram_req_0,
   input sram_bist_pkg::mem_req_t sram_req_1,
   input sram_bist_pkg::mem_rsp_t sram_rsp_0,
   input sram_bist_pkg::mem_rsp_t sram_rsp_1
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;   // failed assertions, summed into the closing line

   // ------------------------------------------------------------------------
   // chip requests hold until acked
   // ------------------------------------------------------------------------
   req_0_held: assert property (@(posedge clk) disable iff (reset)
      sram_req_0.req && !sram_rsp_0.ack |=> $stable(sram_req_0))
      else begin
         fail_count++;
         $error("chip 0 request changed before ack");
      end

   req_1_held: assert property (@(posedge clk) disable iff (reset)
      sram_req_1.req && !sram_rsp_1.ack |=> $stable(sram_req_1))
      else begin
         fail_count++;
         $error("chip 1 request changed before ack");
      end

   // status outputs
   run_done_excl: assert property (@(posedge clk) disable iff (reset) !(running && done))
      else begin
         fail_count++;
         $error("running and done high together");
      end

   log_in_run: assert property (@(posedge clk) disable iff (reset) err_log.vld |-> running)
      else begin
         fail_count++;
         $error("log record outside a run");
      end

   idle_after_reset: assert property (@(posedge clk) reset |=> !running)
      else begin
         fail_count++;
         $error("running high right after reset");
      end

endmodule

bind bist_sequencer sram_bist_chk u_chk (
   .clk        (clk),
   .reset      (reset),
   .running    (running),
   .done       (done),
   .err_log    (err_log),
   .sram_req_0 (sram_req_0),
   .sram_req_1 (sram_req_1),
   .sram_rsp_0 (sram_rsp_0),
   .sram_rsp_1 (sram_rsp_1)
);

//--- test/tb_sram_bist.sv
// testbench top for the SRAM BIST, runs the test scenarios on two SRAM models and checks results
module tb_sram_bist;
   timeunit 1ns;
   timeprecision 1ps;
   import sram_bist_pkg::*;

   localparam int seed_value     = 47260;
   localparam int timeout_cycles = 40000;   // worst case run is about 26k cycles

   typedef struct packed {
      logic       en;
      sram_addr_t addr;
      logic [5:0] bit_idx;
   } fault_t;

   logic       clk;
   logic       reset;
   logic       test_start;
   test_mask_t test_en;
   chip_mask_t sram_en;
   sram_data_t rand_seed;
   logic       running;
   logic       done;
   logic       fail;
   err_log_t   err_log;
   mem_req_t   sram_req_0;
   mem_req_t   sram_req_1;
   mem_rsp_t   sram_rsp_0;
   mem_rsp_t   sram_rsp_1;
   fault_t     fault_0;
   fault_t     fault_1;

   err_log_t   exp_q[$];          // expected records in arrival order
   logic       exp_fail;
   int         value_errors = 0;
   int         other_errors = 0;
   int         req_cycles_0 = 0;
   int         req_cycles_1 = 0;

   sram_bist_top dut (
      .clk        (clk),
      .reset      (reset),
      .test_start (test_start),
      .test_en    (test_en),
      .sram_en    (sram_en),
      .rand_seed  (rand_seed),
      .running    (running),
      .done       (done),
      .fail       (fail),
      .err_log    (err_log),
      .sram_req_0 (sram_req_0),
      .sram_req_1 (sram_req_1),
      .sram_rsp_0 (sram_rsp_0),
      .sram_rsp_1 (sram_rsp_1)
   );

   sram_model mem_0 (
      .clk        (clk),
      .reset      (reset),
      .req        (sram_req_0),
      .rsp        (sram_rsp_0),
      .fault_en   (fault_0.en),
      .fault_addr (fault_0.addr),
      .fault_bit  (fault_0.bit_idx)
   );

   sram_model mem_1 (
      .clk        (clk),
      .reset      (reset),
      .req        (sram_req_1),
      .rsp        (sram_rsp_1),
      .fault_en   (fault_1.en),
      .fault_addr (fault_1.addr),
      .fault_bit  (fault_1.bit_idx)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------------

   // expected and read word of one read, returns the mismatch
   function automatic logic ref_read(input int test, input sram_addr_t addr,
                                     input sram_data_t seed_in, input fault_t f,
                                     output sram_data_t exp_word, output sram_data_t rd_word);
      sram_data_t v;
      int         k;
      case (test)
         0:       exp_word = '0;
         1:       exp_word = '1;
         2:       exp_word = {18{2'b01}};
         3:       exp_word = {18{2'b10}};
         default: begin
            v = (seed_in == '0) ? '1 : seed_in;
            for (k = 0; k < addr; k++)
               v = {v[34:0], v[35] ^ v[24]};   // taps 35 and 24
            exp_word = v;
         end
      endcase
      rd_word = exp_word;
      if (f.en && f.addr == addr)
         rd_word[f.bit_idx] = 1'b1;
      return rd_word != exp_word;
   endfunction

   function automatic int first_zero_bit(input sram_data_t w);
      int b;
      b = 0;
      while (w[b] && b < 35)
         b++;
      return b;
   endfunction

   task automatic build_expected(input test_mask_t te, input chip_mask_t ce,
                                 input sram_data_t sd);
      fault_t     f;
      sram_data_t exp_word;
      sram_data_t rd_word;
      int         c;
      int         t;
      int         a;
      exp_q.delete();
      exp_fail = 1'b0;
      for (c = 0; c < num_chips; c++) begin
         f = (c == 0) ? fault_0 : fault_1;
         for (t = 0; t < num_tests; t++) begin
            for (a = 0; a < 2**sram_addr_width; a++) begin
               if (ce[c] && te[t] && ref_read(t, sram_addr_t'(a), sd, f, exp_word, rd_word)) begin
                  exp_q.push_back('{vld: 1'b1, chip: c[0], addr: sram_addr_t'(a),
                                    exp_data: exp_word, rd_data: rd_word});
                  exp_fail = 1'b1;
               end
            end
         end
      end
   endtask

   // ------------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------------
   task automatic check_log(input err_log_t exp, input err_log_t got);
      string e_s;
      string g_s;
      if (got !== exp) begin
         value_errors++;
         e_s = $sformatf("chip %0d addr %h exp %h rd %h",
                         exp.chip, exp.addr, exp.exp_data, exp.rd_data);
         g_s = $sformatf("chip %0d addr %h exp %h rd %h",
                         got.chip, got.addr, got.exp_data, got.rd_data);
         $display("** Error at %0t: err_log expected %s, got %s", $time, e_s, g_s);
      end
   endtask

   task automatic check_status(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, got);
      end
   endtask

   task automatic check_word(input string name, input sram_data_t exp, input sram_data_t got);
      if (got !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
      end
   endtask

   // each log record must match the head of the expected list
   always @(negedge clk) begin
      if (!reset && err_log.vld) begin
         if (exp_q.size() == 0) begin
            other_errors++;
            $display("unexpected log record at %0t for chip %0d address %h",
                     $time, err_log.chip, err_log.addr);
         end else begin
            check_log(exp_q.pop_front(), err_log);
         end
      end
   end

   always @(negedge clk) begin
      if (sram_req_0.req)
         req_cycles_0++;
      if (sram_req_1.req)
         req_cycles_1++;
   end

   // ------------------------------------------------------------------------
   // run control
   // ------------------------------------------------------------------------
   task automatic finish_run();
      $display("errors: %0d value, %0d other, %0d assertion",
               value_errors, other_errors, dut.u_seq.u_chk.fail_count);
      if (value_errors == 0 && other_errors == 0 && dut.u_seq.u_chk.fail_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   endtask

   task automatic run_bist(input string name, input test_mask_t te, input chip_mask_t ce,
                           input sram_data_t sd);
      int base_0;
      int base_1;
      int n;
      @(negedge clk);
      test_en    = te;
      sram_en    = ce;
      rand_seed  = sd;
      test_start = 1'b1;
      build_expected(te, ce, sd);
      @(negedge clk);
      test_start = 1'b0;
      base_0     = req_cycles_0;
      base_1     = req_cycles_1;
      check_status("running", 1'b1, running);   // start clears the old result
      check_status("done", 1'b0, done);
      check_status("fail", 1'b0, fail);
      n = 0;
      while (!done && n < timeout_cycles) begin
         @(negedge clk);
         n++;
      end
      if (!done) begin
         other_errors++;
         $display("%s: done did not rise within %0d cycles", name, timeout_cycles);
         finish_run();
      end else begin
         check_status("fail", exp_fail, fail);
         check_status("running", 1'b0, running);
         if (exp_q.size() != 0) begin
            other_errors++;
            $display("%s: %0d expected log records never appeared", name, exp_q.size());
         end
         if ((!ce[0] || te == '0) && req_cycles_0 != base_0) begin
            other_errors++;
            $display("%s: chip 0 saw requests although it had nothing to run", name);
         end
         if ((!ce[1] || te == '0) && req_cycles_1 != base_1) begin
            other_errors++;
            $display("%s: chip 1 saw requests although it had nothing to run", name);
         end
      end
   endtask

   task automatic check_memories(input sram_data_t sd);
      sram_data_t exp_word;
      sram_data_t rd_word;
      int         a;
      for (a = 0; a < 2**sram_addr_width; a++) begin
         void'(ref_read(rand_test_idx, sram_addr_t'(a), sd, '0, exp_word, rd_word));
         check_word($sformatf("mem_0.mem[%0d]", a), exp_word, mem_0.mem[a]);
         check_word($sformatf("mem_1.mem[%0d]", a), exp_word, mem_1.mem[a]);
      end
   endtask

   // ------------------------------------------------------------------------
   // scenarios
   // ------------------------------------------------------------------------
   initial begin
      sram_data_t seed_a;
      sram_data_t seed_b;
      sram_data_t exp_word;
      sram_data_t rd_word;
      sram_addr_t flt_addr;
      void'($urandom(seed_value));
      reset      = 1'b1;
      test_start = 1'b0;
      test_en    = '0;
      sram_en    = '0;
      rand_seed  = '0;
      fault_0    = '0;
      fault_1    = '0;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      check_status("running", 1'b0, running);
      check_status("done", 1'b0, done);
      check_status("fail", 1'b0, fail);
      check_status("sram_req_0.req", 1'b0, sram_req_0.req);
      check_status("sram_req_1.req", 1'b0, sram_req_1.req);
      check_status("err_log.vld", 1'b0, err_log.vld);

      // everything on, no fault, random test writes last
      seed_a = sram_data_t'({$urandom, $urandom});
      run_bist("fault-free", 5'h1f, 2'b11, seed_a);
      check_memories(seed_a);

      fault_1 = '{en: 1'b1, addr: sram_addr_t'($urandom_range(255, 0)),
                  bit_idx: 6'($urandom_range(35, 0))};
      run_bist("stuck bit on chip 1", 5'h1f, 2'b11, seed_a);

      // restart after a failing run, faulty chip masked off
      run_bist("chip 1 masked", 5'h1f, 2'b01, seed_a);

      // fault on a bit the LFSR word leaves at zero
      seed_b   = sram_data_t'({$urandom, $urandom});
      flt_addr = sram_addr_t'($urandom_range(255, 0));
      void'(ref_read(rand_test_idx, flt_addr, seed_b, '0, exp_word, rd_word));
      fault_1 = '0;
      fault_0 = '{en: 1'b1, addr: flt_addr, bit_idx: 6'(first_zero_bit(exp_word))};
      run_bist("random test only", 5'b10000, 2'b11, seed_b);

      run_bist("nothing enabled", 5'b00000, 2'b11, seed_b);

      // zero seed falls back to all ones
      flt_addr = sram_addr_t'($urandom_range(255, 0));
      void'(ref_read(rand_test_idx, flt_addr, '0, '0, exp_word, rd_word));
      fault_0 = '0;
      fault_1 = '{en: 1'b1, addr: flt_addr, bit_idx: 6'(first_zero_bit(exp_word))};
      run_bist("zero seed", 5'b10000, 2'b11, '0);

      finish_run();
   end

endmodule

//--- tb.f
src/sram_bist_pkg.sv
src/fixed_pattern_tester.sv
src/random_pattern_tester.sv
src/bist_sequencer.sv
src/sram_bist_top.sv
test/sram_model.sv
test/sram_bist_chk.sv
test/tb_sram_bist.sv

//--- Bender.yml
package:
  name: sram_bist

sources:
  # synthesizable design, package first
  - files:
      - src/sram_bist_pkg.sv
      - src/fixed_pattern_tester.sv
      - src/random_pattern_tester.sv
      - src/bist_sequencer.sv
      - src/sram_bist_top.sv

  # simulation only, top module tb_sram_bist
  - target: test
    files:
      - test/sram_model.sv
      - test/sram_bist_chk.sv
      - test/tb_sram_bist.sv
